// ==== logic/isa_pkg.sv ====
package isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // major opcode field, bits [6:0] of the instruction word
    ////////////////////////////////////////////////////////////////////////////

    localparam int opcode_width = 7;

    typedef logic [opcode_width-1:0] opcode_t;

    // loads and stores
    localparam opcode_t op_load   = 7'b0000011;  // lb, lh, lw, lbu, lhu
    localparam opcode_t op_store  = 7'b0100011;  // sb, sh, sw

    // arithmetic and logic
    localparam opcode_t op_rtype  = 7'b0110011;  // register-register
    localparam opcode_t op_itype  = 7'b0010011;  // register-immediate

    // control transfer
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_branch = 7'b1100011;  // beq, bne, blt, bge, ...
    localparam opcode_t op_jalr   = 7'b1100111;

    // upper immediates
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_lui    = 7'b0110111;

    // csr access; ecall and ebreak share this opcode
    localparam opcode_t op_system = 7'b1110011;

endpackage

// ==== logic/ctrl_pkg.sv ====
package ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // FSM states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        fetch       = 6'd0,
        decode      = 6'd1,
        mem_addr    = 6'd2,
        mem_read    = 6'd3,
        mem_wb      = 6'd4,
        mem_write   = 6'd5,
        execute_r   = 6'd6,
        alu_wb      = 6'd7,
        execute_i   = 6'd8,
        jal         = 6'd9,
        branch      = 6'd10,
        jalr        = 6'd11,
        auipc       = 6'd12,
        lui         = 6'd13,
        jalr_target = 6'd14,
        execute_csr = 6'd15
    } state_t;

    ////////////////////////////////////////////////////////////////////////////
    // datapath mux selects
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        addr_pc    = 2'b00,
        addr_saved = 2'b10     // address latched by save_address
    } addr_sel_t;

    typedef enum logic [1:0] {
        alu_add     = 2'b00,
        alu_compare = 2'b01,   // branch condition
        alu_funct   = 2'b10    // operation from funct3/funct7
    } alu_op_t;

    typedef enum logic [2:0] {
        a_pc     = 3'b000,
        a_rs1    = 3'b001,
        a_old_pc = 3'b010,     // pc of the instruction being executed
        a_zero   = 3'b011
    } src_a_t;

    typedef enum logic [2:0] {
        b_rs2  = 3'b000,
        b_four = 3'b001,
        b_imm  = 3'b010
    } src_b_t;

    typedef enum logic [2:0] {
        wb_alu = 3'b000,
        wb_mem = 3'b001,
        wb_csr = 3'b010
    } wb_sel_t;

    ////////////////////////////////////////////////////////////////////////////
    // control word to the datapath
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic      pc_write;
        logic      pc_write_cond;
        logic      pc_source;         // 1 selects the alu result register
        logic      ir_write;
        logic      reg_write;
        logic      memory_read;
        logic      memory_write;
        logic      is_immediate;
        logic      csr_write_enable;
        logic      save_address;
        addr_sel_t address_select;
        alu_op_t   alu_op;
        src_a_t    alu_src_a;
        src_b_t    alu_src_b;
        wb_sel_t   memory_to_reg;
    } ctrl_word_t;

    localparam ctrl_word_t idle_word = '{
        pc_write:         1'b0,
        pc_write_cond:    1'b0,
        pc_source:        1'b0,
        ir_write:         1'b0,
        reg_write:        1'b0,
        memory_read:      1'b0,
        memory_write:     1'b0,
        is_immediate:     1'b0,
        csr_write_enable: 1'b0,
        save_address:     1'b0,
        address_select:   addr_pc,
        alu_op:           alu_add,
        alu_src_a:        a_pc,
        alu_src_b:        b_rs2,
        memory_to_reg:    wb_alu
    };

endpackage

// ==== logic/state_sequencer.sv ====
`timescale 1ns/1ps

module state_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  logic              memory_response,
    input  isa_pkg::opcode_t  instruction_opcode,
    output ctrl_pkg::state_t  state,
    output logic              fetch_accept
);

    ctrl_pkg::state_t next_state;

    assign fetch_accept = (state == ctrl_pkg::fetch) && memory_response;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ctrl_pkg::fetch;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = ctrl_pkg::fetch;
        case (state)
            ctrl_pkg::fetch: begin
                if (fetch_accept) begin
                    next_state = ctrl_pkg::decode;
                end else begin
                    next_state = ctrl_pkg::fetch;    // wait for the instruction
                end
            end
            ctrl_pkg::decode: begin
                case (instruction_opcode)
                    isa_pkg::op_load:   next_state = ctrl_pkg::mem_addr;
                    isa_pkg::op_store:  next_state = ctrl_pkg::mem_addr;
                    isa_pkg::op_rtype:  next_state = ctrl_pkg::execute_r;
                    isa_pkg::op_itype:  next_state = ctrl_pkg::execute_i;
                    isa_pkg::op_jal:    next_state = ctrl_pkg::jal;
                    isa_pkg::op_branch: next_state = ctrl_pkg::branch;
                    isa_pkg::op_jalr:   next_state = ctrl_pkg::jalr_target;
                    isa_pkg::op_auipc:  next_state = ctrl_pkg::auipc;
                    isa_pkg::op_lui:    next_state = ctrl_pkg::lui;
                    isa_pkg::op_system: next_state = ctrl_pkg::execute_csr;
                    default:            next_state = ctrl_pkg::fetch;  // unknown opcode
                endcase
            end
            ctrl_pkg::mem_addr: begin
                // only loads and stores get here
                if (instruction_opcode == isa_pkg::op_load) begin
                    next_state = ctrl_pkg::mem_read;
                end else begin
                    next_state = ctrl_pkg::mem_write;
                end
            end
            ctrl_pkg::mem_read: begin
                if (memory_response) begin
                    next_state = ctrl_pkg::mem_wb;
                end else begin
                    next_state = ctrl_pkg::mem_read;
                end
            end
            ctrl_pkg::mem_write: begin
                if (memory_response) begin
                    next_state = ctrl_pkg::fetch;
                end else begin
                    next_state = ctrl_pkg::mem_write;
                end
            end
            ctrl_pkg::execute_r:   next_state = ctrl_pkg::alu_wb;
            ctrl_pkg::execute_i:   next_state = ctrl_pkg::alu_wb;
            ctrl_pkg::jal:         next_state = ctrl_pkg::alu_wb;   // link rd = old pc + 4
            ctrl_pkg::jalr_target: next_state = ctrl_pkg::jalr;
            ctrl_pkg::jalr:        next_state = ctrl_pkg::alu_wb;
            ctrl_pkg::auipc:       next_state = ctrl_pkg::alu_wb;
            ctrl_pkg::lui:         next_state = ctrl_pkg::alu_wb;
            ctrl_pkg::mem_wb:      next_state = ctrl_pkg::fetch;
            ctrl_pkg::alu_wb:      next_state = ctrl_pkg::fetch;
            ctrl_pkg::branch:      next_state = ctrl_pkg::fetch;
            ctrl_pkg::execute_csr: next_state = ctrl_pkg::fetch;
            default:               next_state = ctrl_pkg::fetch;
        endcase
    end

endmodule

// ==== logic/control_word_decoder.sv ====
`timescale 1ns/1ps

module control_word_decoder (
    input  ctrl_pkg::state_t    state,
    input  logic                fetch_accept,
    output ctrl_pkg::ctrl_word_t ctrl
);

    always_comb begin
        ctrl = ctrl_pkg::idle_word;
        case (state)
            ////////////////////////////////////////////////////////////////////
            // instruction fetch and decode
            ////////////////////////////////////////////////////////////////////
            ctrl_pkg::fetch: begin
                ctrl.memory_read    = 1'b1;
                ctrl.address_select = ctrl_pkg::addr_pc;
                ctrl.alu_src_b      = ctrl_pkg::b_four;    // pc + 4
                if (fetch_accept) begin
                    ctrl.pc_write = 1'b1;
                    ctrl.ir_write = 1'b1;
                end
            end
            ctrl_pkg::decode: begin
                // branch target computed early, used by branch state
                ctrl.alu_src_a = ctrl_pkg::a_old_pc;
                ctrl.alu_src_b = ctrl_pkg::b_imm;
            end

            ////////////////////////////////////////////////////////////////////
            // memory access
            ////////////////////////////////////////////////////////////////////
            ctrl_pkg::mem_addr: begin
                ctrl.alu_src_a    = ctrl_pkg::a_rs1;
                ctrl.alu_src_b    = ctrl_pkg::b_imm;
                ctrl.save_address = 1'b1;              // latch rs1 + imm
            end
            ctrl_pkg::mem_read: begin
                ctrl.memory_read    = 1'b1;
                ctrl.address_select = ctrl_pkg::addr_saved;
            end
            ctrl_pkg::mem_write: begin
                ctrl.memory_write   = 1'b1;
                ctrl.address_select = ctrl_pkg::addr_saved;
            end
            ctrl_pkg::mem_wb: begin
                ctrl.reg_write     = 1'b1;
                ctrl.memory_to_reg = ctrl_pkg::wb_mem;
            end

            ////////////////////////////////////////////////////////////////////
            // alu, jumps and branches
            ////////////////////////////////////////////////////////////////////
            ctrl_pkg::execute_r: begin
                ctrl.alu_src_a = ctrl_pkg::a_rs1;
                ctrl.alu_op    = ctrl_pkg::alu_funct;
            end
            ctrl_pkg::execute_i: begin
                ctrl.alu_src_a    = ctrl_pkg::a_rs1;
                ctrl.alu_src_b    = ctrl_pkg::b_imm;
                ctrl.alu_op       = ctrl_pkg::alu_funct;
                ctrl.is_immediate = 1'b1;
            end
            ctrl_pkg::alu_wb: begin
                ctrl.reg_write = 1'b1;                  // rd from alu result
            end
            ctrl_pkg::jal: begin
                ctrl.alu_src_a = ctrl_pkg::a_old_pc;
                ctrl.alu_src_b = ctrl_pkg::b_four;
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = 1'b1;                  // target from decode
            end
            ctrl_pkg::branch: begin
                ctrl.alu_src_a     = ctrl_pkg::a_rs1;
                ctrl.alu_op        = ctrl_pkg::alu_compare;
                ctrl.pc_write_cond = 1'b1;
                ctrl.pc_source     = 1'b1;
            end
            ctrl_pkg::jalr_target: begin
                ctrl.alu_src_a = ctrl_pkg::a_rs1;
                ctrl.alu_src_b = ctrl_pkg::b_imm;
            end
            ctrl_pkg::jalr: begin
                ctrl.alu_src_a    = ctrl_pkg::a_old_pc;
                ctrl.alu_src_b    = ctrl_pkg::b_four;
                ctrl.pc_write     = 1'b1;
                ctrl.pc_source    = 1'b1;
                ctrl.is_immediate = 1'b1;               // clears bit 0 of the target
            end
            ctrl_pkg::auipc: begin
                ctrl.alu_src_a = ctrl_pkg::a_old_pc;
                ctrl.alu_src_b = ctrl_pkg::b_imm;
            end
            ctrl_pkg::lui: begin
                ctrl.alu_src_a = ctrl_pkg::a_zero;
                ctrl.alu_src_b = ctrl_pkg::b_imm;
            end
            ctrl_pkg::execute_csr: begin
                ctrl.reg_write        = 1'b1;
                ctrl.memory_to_reg    = ctrl_pkg::wb_csr;   // old csr value to rd
                ctrl.csr_write_enable = 1'b1;
            end
            default: begin
                ctrl = ctrl_pkg::idle_word;
            end
        endcase
    end

endmodule

// ==== logic/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 memory_response,
    input  isa_pkg::opcode_t     instruction_opcode,
    output ctrl_pkg::ctrl_word_t ctrl
);

    ctrl_pkg::state_t state;
    logic             fetch_accept;   // instruction accepted this cycle

    ////////////////////////////////////////////////////////////////////////////
    // FSM state register and next-state logic
    ////////////////////////////////////////////////////////////////////////////

    state_sequencer sequencer0 (
        .clk                (clk),
        .reset              (reset),
        .memory_response    (memory_response),
        .instruction_opcode (instruction_opcode),
        .state              (state),
        .fetch_accept       (fetch_accept)
    );

    ////////////////////////////////////////////////////////////////////////////
    // per-state control word
    ////////////////////////////////////////////////////////////////////////////

    control_word_decoder decoder0 (
        .state        (state),
        .fetch_accept (fetch_accept),
        .ctrl         (ctrl)
    );

endmodule

// ==== verification/control_unit_checker.sv ====
`timescale 1ns/1ps

module control_unit_checker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 memory_response,
    input  isa_pkg::opcode_t     instruction_opcode,
    input  ctrl_pkg::ctrl_word_t ctrl,
    output int                   error_count,
    output int                   checked_cycles
);

    ctrl_pkg::state_t model_state;

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic ctrl_pkg::state_t model_next(input ctrl_pkg::state_t s,
                                                    input logic resp,
                                                    input isa_pkg::opcode_t op);
        ctrl_pkg::state_t n;
        n = ctrl_pkg::fetch;
        case (s)
            ctrl_pkg::fetch:     n = resp ? ctrl_pkg::decode : ctrl_pkg::fetch;
            ctrl_pkg::mem_addr:  n = (op == isa_pkg::op_load) ? ctrl_pkg::mem_read
                                                               : ctrl_pkg::mem_write;
            ctrl_pkg::mem_read:  n = resp ? ctrl_pkg::mem_wb : ctrl_pkg::mem_read;
            ctrl_pkg::mem_write: n = resp ? ctrl_pkg::fetch : ctrl_pkg::mem_write;
            ctrl_pkg::jalr_target: n = ctrl_pkg::jalr;
            ctrl_pkg::execute_r, ctrl_pkg::execute_i, ctrl_pkg::jal, ctrl_pkg::jalr,
            ctrl_pkg::auipc, ctrl_pkg::lui: n = ctrl_pkg::alu_wb;
            ctrl_pkg::decode: begin
                case (op)
                    isa_pkg::op_load, isa_pkg::op_store: n = ctrl_pkg::mem_addr;
                    isa_pkg::op_rtype:  n = ctrl_pkg::execute_r;
                    isa_pkg::op_itype:  n = ctrl_pkg::execute_i;
                    isa_pkg::op_jal:    n = ctrl_pkg::jal;
                    isa_pkg::op_branch: n = ctrl_pkg::branch;
                    isa_pkg::op_jalr:   n = ctrl_pkg::jalr_target;
                    isa_pkg::op_auipc:  n = ctrl_pkg::auipc;
                    isa_pkg::op_lui:    n = ctrl_pkg::lui;
                    isa_pkg::op_system: n = ctrl_pkg::execute_csr;
                    default:            n = ctrl_pkg::fetch;   // unknown opcode
                endcase
            end
            default: n = ctrl_pkg::fetch;
        endcase
        return n;
    endfunction

    // each field written as the set of states that raise it
    function automatic ctrl_pkg::ctrl_word_t model_word(input ctrl_pkg::state_t s,
                                                        input logic resp);
        ctrl_pkg::ctrl_word_t w;
        logic                 accept;
        accept = (s == ctrl_pkg::fetch) && resp;
        w = ctrl_pkg::idle_word;
        w.pc_write         = accept || (s inside {ctrl_pkg::jal, ctrl_pkg::jalr});
        w.pc_write_cond    = (s == ctrl_pkg::branch);
        w.pc_source        = s inside {ctrl_pkg::jal, ctrl_pkg::jalr, ctrl_pkg::branch};
        w.ir_write         = accept;
        w.reg_write        = s inside {ctrl_pkg::mem_wb, ctrl_pkg::alu_wb, ctrl_pkg::execute_csr};
        w.memory_read      = s inside {ctrl_pkg::fetch, ctrl_pkg::mem_read};
        w.memory_write     = (s == ctrl_pkg::mem_write);
        w.is_immediate     = s inside {ctrl_pkg::execute_i, ctrl_pkg::jalr};
        w.csr_write_enable = (s == ctrl_pkg::execute_csr);
        w.save_address     = (s == ctrl_pkg::mem_addr);
        w.address_select   = (s inside {ctrl_pkg::mem_read, ctrl_pkg::mem_write}) ?
                             ctrl_pkg::addr_saved : ctrl_pkg::addr_pc;
        w.alu_op           = (s inside {ctrl_pkg::execute_r, ctrl_pkg::execute_i}) ?
                             ctrl_pkg::alu_funct :
                             (s == ctrl_pkg::branch) ? ctrl_pkg::alu_compare : ctrl_pkg::alu_add;
        w.alu_src_a        = (s inside {ctrl_pkg::mem_addr, ctrl_pkg::execute_r, ctrl_pkg::execute_i,
                                        ctrl_pkg::branch, ctrl_pkg::jalr_target}) ? ctrl_pkg::a_rs1 :
                             (s inside {ctrl_pkg::decode, ctrl_pkg::jal, ctrl_pkg::jalr,
                                        ctrl_pkg::auipc}) ? ctrl_pkg::a_old_pc :
                             (s == ctrl_pkg::lui) ? ctrl_pkg::a_zero : ctrl_pkg::a_pc;
        w.alu_src_b        = (s inside {ctrl_pkg::fetch, ctrl_pkg::jal, ctrl_pkg::jalr}) ?
                             ctrl_pkg::b_four :
                             (s inside {ctrl_pkg::decode, ctrl_pkg::mem_addr, ctrl_pkg::execute_i,
                                        ctrl_pkg::jalr_target, ctrl_pkg::auipc, ctrl_pkg::lui}) ?
                             ctrl_pkg::b_imm : ctrl_pkg::b_rs2;
        w.memory_to_reg    = (s == ctrl_pkg::mem_wb) ? ctrl_pkg::wb_mem :
                             (s == ctrl_pkg::execute_csr) ? ctrl_pkg::wb_csr : ctrl_pkg::wb_alu;
        return w;
    endfunction

    task automatic check_field(input string name, input int got, input int want);
        if (got != want) begin
            error_count++;
            $display("Error: %0d ns state %s field %s is %0d, expected %0d",
                     $time, model_state.name(), name, got, want);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            model_state <= ctrl_pkg::fetch;
        end else begin
            model_state <= model_next(model_state, memory_response, instruction_opcode);
        end
    end

    // compare away from the clock edge
    always @(negedge clk) begin
        ctrl_pkg::ctrl_word_t want;
        if (reset) begin
            error_count = 0;
            checked_cycles = 0;
        end else begin
            want = model_word(model_state, memory_response);
            checked_cycles++;
            check_field("pc_write", int'(ctrl.pc_write), int'(want.pc_write));
            check_field("pc_write_cond", int'(ctrl.pc_write_cond), int'(want.pc_write_cond));
            check_field("pc_source", int'(ctrl.pc_source), int'(want.pc_source));
            check_field("ir_write", int'(ctrl.ir_write), int'(want.ir_write));
            check_field("reg_write", int'(ctrl.reg_write), int'(want.reg_write));
            check_field("memory_read", int'(ctrl.memory_read), int'(want.memory_read));
            check_field("memory_write", int'(ctrl.memory_write), int'(want.memory_write));
            check_field("is_immediate", int'(ctrl.is_immediate), int'(want.is_immediate));
            check_field("csr_write_enable", int'(ctrl.csr_write_enable),
                        int'(want.csr_write_enable));
            check_field("save_address", int'(ctrl.save_address), int'(want.save_address));
            check_field("address_select", int'(ctrl.address_select), int'(want.address_select));
            check_field("alu_op", int'(ctrl.alu_op), int'(want.alu_op));
            check_field("alu_src_a", int'(ctrl.alu_src_a), int'(want.alu_src_a));
            check_field("alu_src_b", int'(ctrl.alu_src_b), int'(want.alu_src_b));
            check_field("memory_to_reg", int'(ctrl.memory_to_reg), int'(want.memory_to_reg));
        end
    end

endmodule

// ==== verification/control_unit_props.sv ====
`timescale 1ns/1ps

module control_unit_props (
    input logic                 clk,
    input logic                 reset,
    input logic                 memory_response,
    input ctrl_pkg::ctrl_word_t ctrl
);

    read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.memory_read && ctrl.memory_write))
        else $error("memory_read and memory_write high together");

    // instruction register loads only with the fetched word present
    ir_write_needs_response: assert property (@(posedge clk) disable iff (reset)
        ctrl.ir_write |-> memory_response)
        else $error("ir_write high without memory_response");

    no_reg_write_on_store: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.reg_write && ctrl.memory_write))
        else $error("reg_write and memory_write high together");

endmodule

bind control_unit control_unit_props props0 (
    .clk             (clk),
    .reset           (reset),
    .memory_response (memory_response),
    .ctrl            (ctrl)
);

// ==== verification/control_unit_tb.sv ====
`timescale 1ns/1ps

module control_unit_tb;

    localparam int fetch_target = 400;      // instructions to run
    localparam int cycle_limit  = 20000;

    // ten supported opcodes, twice the memory ones, then a few unknown ones
    localparam isa_pkg::opcode_t opcode_table [16] = '{
        isa_pkg::op_load, isa_pkg::op_store, isa_pkg::op_rtype, isa_pkg::op_itype,
        isa_pkg::op_jal, isa_pkg::op_branch, isa_pkg::op_jalr, isa_pkg::op_auipc,
        isa_pkg::op_lui, isa_pkg::op_system, isa_pkg::op_load, isa_pkg::op_store,
        7'b0001111, 7'b0000000, 7'b1111111, 7'b0101011
    };

    logic                 clk = 1'b0;
    logic                 reset = 1'b1;
    logic                 memory_response = 1'b0;
    isa_pkg::opcode_t     instruction_opcode = '0;
    ctrl_pkg::ctrl_word_t ctrl;
    logic [31:0]          lfsr = 32'd74256;
    int                   fetches = 0;
    int                   error_count;
    int                   checked_cycles;

    always #4 clk = ~clk;

    control_unit dut0 (
        .clk                (clk),
        .reset              (reset),
        .memory_response    (memory_response),
        .instruction_opcode (instruction_opcode),
        .ctrl               (ctrl)
    );

    control_unit_checker checker0 (
        .clk                (clk),
        .reset              (reset),
        .memory_response    (memory_response),
        .instruction_opcode (instruction_opcode),
        .ctrl               (ctrl),
        .error_count        (error_count),
        .checked_cycles     (checked_cycles)
    );

    ////////////////////////////////////////////////////////////////////////////
    // random source
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [3:0] random_bits(input int count);
        logic [3:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return value;
    endfunction

    always @(posedge clk) begin
        if (!reset) begin
            memory_response <= (random_bits(2) != 4'd0);    // low about one cycle in four
            if (ctrl.ir_write) begin
                instruction_opcode <= opcode_table[random_bits(4)];  // new instruction
                fetches <= fetches + 1;
            end
        end
    end

    initial begin
        int  cycles;
        bit  timed_out;
        cycles = 0;
        timed_out = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        while (fetches < fetch_target && cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (fetches < fetch_target) begin
            $display("timeout: only %0d of %0d instructions fetched in %0d cycles",
                     fetches, fetch_target, cycles);
            timed_out = 1'b1;
        end
        @(posedge clk);     // counts settle at the negedge before this
        $display("cycles checked %0d, errors %0d, timeouts %0d",
                 checked_cycles, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/state_sequencer.sv
logic/control_word_decoder.sv
logic/control_unit.sv
verification/control_unit_checker.sv
verification/control_unit_props.sv
verification/control_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module control_unit_tb \
    -f list.f -o control_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/control_unit_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^All tests passed$"; then
    exit 0
fi
exit 1
